// File: design/cache_pkg.sv
package cache_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Requester word and line geometry
	// ~~~~~~~~~~~~~~~~~~~~

	localparam int ADDR_WIDTH     = 16;   // Word address from the requester
	localparam int WORD_WIDTH     = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_WIDTH   = $clog2(WORDS_PER_LINE);
	localparam int LINE_WIDTH     = WORD_WIDTH * WORDS_PER_LINE;

	// ~~~~~~~~~~~~~~~~~~~~
	// Banking and set indexing
	// ~~~~~~~~~~~~~~~~~~~~

	localparam int NUM_BANKS      = 4;
	localparam int BANK_WIDTH     = $clog2(NUM_BANKS);
	localparam int SETS_PER_BANK  = 16;
	localparam int SET_WIDTH      = $clog2(SETS_PER_BANK);

	// Bit positions of each field inside the word address
	// Order from the top is tag, set, bank, offset
	localparam int BANK_LSB       = OFFSET_WIDTH;
	localparam int SET_LSB        = BANK_LSB + BANK_WIDTH;
	localparam int TAG_LSB        = SET_LSB + SET_WIDTH;
	localparam int TAG_WIDTH      = ADDR_WIDTH - TAG_LSB;

	// ~~~~~~~~~~~~~~~~~~~~
	// Memory port
	// ~~~~~~~~~~~~~~~~~~~~

	// The memory moves whole lines, so its address drops the word offset
	localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

endpackage

// File: design/line_store.sv
module line_store (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           lookup,
	input  logic [cache_pkg::SET_WIDTH-1:0]  set,
	input  logic [cache_pkg::TAG_WIDTH-1:0]  tag,
	input  logic                           write_en,
	input  logic [cache_pkg::LINE_WIDTH-1:0] data_write,
	input  logic                           dirty_write,
	output logic [cache_pkg::LINE_WIDTH-1:0] data_read,
	output logic                           dirty_read,
	output logic                           hit,
	output logic [cache_pkg::TAG_WIDTH-1:0]  victim_tag
);

	// ~~~~~~~~~~~~~~~~~~~~
	// Storage arrays
	// ~~~~~~~~~~~~~~~~~~~~

	logic [cache_pkg::LINE_WIDTH-1:0] data_mem [cache_pkg::SETS_PER_BANK];
	logic [cache_pkg::TAG_WIDTH-1:0]  tag_mem  [cache_pkg::SETS_PER_BANK];
	logic [cache_pkg::SETS_PER_BANK-1:0] valid_bits;
	logic [cache_pkg::SETS_PER_BANK-1:0] dirty_bits;

	// Registered copy of the looked-up line
	logic [cache_pkg::LINE_WIDTH-1:0] data_q;
	logic [cache_pkg::TAG_WIDTH-1:0]  tag_q;
	logic                             valid_q;
	logic                             dirty_q;

	// Line payload, tag and dirty storage
	always_ff @(posedge clk) begin
		if (lookup) begin
			data_q <= data_mem[set];
			tag_q  <= tag_mem[set];
		end
		if (write_en) begin
			data_mem[set]   <= data_write;
			tag_mem[set]    <= tag;         // The tag comes from the current request
			dirty_bits[set] <= dirty_write;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_bits <= '0;
			valid_q    <= 1'b0;
			dirty_q    <= 1'b0;
		end else begin
			if (lookup) begin
				valid_q <= valid_bits[set];
				// An invalid line never reports dirty
				dirty_q <= valid_bits[set] & dirty_bits[set];
			end
			if (write_en)
				valid_bits[set] <= 1'b1;
		end
	end

	assign data_read  = data_q;
	assign dirty_read = dirty_q;
	assign victim_tag = tag_q;   // Stored tag addresses a writeback
	assign hit        = valid_q && (tag_q == tag);

endmodule

// File: design/request_dispatch.sv
module request_dispatch (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              cpu_req,
	input  logic                              cpu_we,
	input  logic [cache_pkg::ADDR_WIDTH-1:0]   cpu_addr,
	input  logic [cache_pkg::WORD_WIDTH-1:0]   cpu_wdata,
	input  logic                              done,
	output logic                              cpu_ack,
	output logic [cache_pkg::NUM_BANKS-1:0]    lookup,
	output logic [cache_pkg::SET_WIDTH-1:0]    set,
	output logic [cache_pkg::TAG_WIDTH-1:0]    tag,
	output logic [cache_pkg::BANK_WIDTH-1:0]   bank,
	output logic [cache_pkg::OFFSET_WIDTH-1:0] offset,
	output logic                              is_write,
	output logic [cache_pkg::WORD_WIDTH-1:0]   wdata,
	output logic                              start
);

	typedef enum logic [1:0] {
		st_idle,
		st_look,      // Bank is reading the addressed line
		st_busy,      // Waiting for the resolver
		st_release    // Ack high, waiting for req to drop
	} state_t;

	state_t state;

	logic [cache_pkg::BANK_WIDTH-1:0] addr_bank;

	assign addr_bank = cpu_addr[cache_pkg::BANK_LSB +: cache_pkg::BANK_WIDTH];

	// ~~~~~~~~~~~~~~~~~~~~
	// Request capture
	// ~~~~~~~~~~~~~~~~~~~~

	// Fields are held for the whole transaction
	always_ff @(posedge clk) begin
		if (state == st_idle && cpu_req) begin
			set      <= cpu_addr[cache_pkg::SET_LSB +: cache_pkg::SET_WIDTH];
			tag      <= cpu_addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_WIDTH];
			bank     <= addr_bank;
			offset   <= cpu_addr[cache_pkg::OFFSET_WIDTH-1:0];
			is_write <= cpu_we;
			wdata    <= cpu_wdata;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Handshake FSM
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= st_idle;
			cpu_ack <= 1'b0;
			lookup  <= '0;
			start   <= 1'b0;
		end else begin
			lookup <= '0;   // Both strobes are single-cycle pulses
			start  <= 1'b0;
			case (state)
				st_idle: if (cpu_req) begin
					lookup[addr_bank] <= 1'b1;
					state             <= st_look;
				end
				st_look: begin
					start <= 1'b1;   // Bank output is valid from here on
					state <= st_busy;
				end
				st_busy: if (done) begin
					cpu_ack <= 1'b1;
					state   <= st_release;
				end
				st_release: if (!cpu_req) begin
					cpu_ack <= 1'b0;
					state   <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: design/lookup_resolver.sv
module lookup_resolver (
	input  logic                                                   clk,
	input  logic                                                   rst_n,
	input  logic                                                   start,
	input  logic [cache_pkg::BANK_WIDTH-1:0]                        bank,
	input  logic [cache_pkg::SET_WIDTH-1:0]                         set,
	input  logic [cache_pkg::TAG_WIDTH-1:0]                         tag,
	input  logic [cache_pkg::OFFSET_WIDTH-1:0]                      offset,
	input  logic                                                   is_write,
	input  logic [cache_pkg::WORD_WIDTH-1:0]                        wdata,
	input  logic [cache_pkg::NUM_BANKS-1:0][cache_pkg::LINE_WIDTH-1:0] data_read,
	input  logic [cache_pkg::NUM_BANKS-1:0]                         dirty_read,
	input  logic [cache_pkg::NUM_BANKS-1:0]                         hit,
	input  logic [cache_pkg::NUM_BANKS-1:0][cache_pkg::TAG_WIDTH-1:0]  victim_tag,
	input  logic                                                   refill_done,
	input  logic [cache_pkg::LINE_WIDTH-1:0]                        refill_line,
	output logic                                                   done,
	output logic [cache_pkg::WORD_WIDTH-1:0]                        cpu_rdata,
	output logic [cache_pkg::NUM_BANKS-1:0]                         write_en,
	output logic [cache_pkg::LINE_WIDTH-1:0]                        data_write,
	output logic                                                   dirty_write,
	output logic                                                   miss_start,
	output logic                                                   victim_dirty,
	output logic [cache_pkg::LINE_ADDR_WIDTH-1:0]                   victim_line_addr,
	output logic [cache_pkg::LINE_WIDTH-1:0]                        victim_data
);

	typedef enum logic [1:0] {
		st_idle,
		st_miss,    // Refill engine owns the memory port
		st_fill     // Refilled line goes into the bank
	} state_t;

	state_t state;

	logic [cache_pkg::LINE_WIDTH-1:0] fill_line;
	logic [cache_pkg::LINE_WIDTH-1:0] base_line;
	logic [cache_pkg::LINE_WIDTH-1:0] merged_line;
	logic [cache_pkg::WORD_WIDTH-1:0] base_word;
	logic                             sel_hit;

	// ~~~~~~~~~~~~~~~~~~~~
	// Bank select and word merge
	// ~~~~~~~~~~~~~~~~~~~~

	assign sel_hit   = hit[bank];
	assign base_line = (state == st_fill) ? fill_line : data_read[bank];
	assign base_word = base_line[offset * cache_pkg::WORD_WIDTH +: cache_pkg::WORD_WIDTH];

	always_comb begin
		merged_line = base_line;
		merged_line[offset * cache_pkg::WORD_WIDTH +: cache_pkg::WORD_WIDTH] = wdata;
	end

	// A write always leaves the line dirty, a read fill leaves it clean
	assign data_write  = is_write ? merged_line : base_line;
	assign dirty_write = is_write;

	// Victim fields for the refill engine
	assign victim_data      = data_read[bank];
	assign victim_line_addr = {victim_tag[bank], set, bank};
	assign victim_dirty     = dirty_read[bank] && (victim_tag[bank] != tag);

	always_comb begin
		done       = 1'b0;
		miss_start = 1'b0;
		write_en   = '0;
		case (state)
			st_idle: if (start) begin
				if (sel_hit) begin
					done           = 1'b1;
					write_en[bank] = is_write;   // Write hit updates in place
				end else begin
					miss_start = 1'b1;
				end
			end
			st_fill: begin
				done           = 1'b1;
				write_en[bank] = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (start && !sel_hit) state <= st_miss;
				st_miss: if (refill_done) state <= st_fill;
				st_fill: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (refill_done)
			fill_line <= refill_line;
		if (done)
			cpu_rdata <= is_write ? wdata : base_word;   // Write returns the new word
	end

endmodule

// File: design/refill_engine.sv
module refill_engine (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 miss_start,
	input  logic                                 victim_dirty,
	input  logic [cache_pkg::LINE_ADDR_WIDTH-1:0] victim_line_addr,
	input  logic [cache_pkg::LINE_WIDTH-1:0]      victim_data,
	input  logic [cache_pkg::LINE_ADDR_WIDTH-1:0] miss_line_addr,
	input  logic                                 mem_ack,
	input  logic [cache_pkg::LINE_WIDTH-1:0]      mem_rdata,
	output logic                                 mem_req,
	output logic                                 mem_we,
	output logic [cache_pkg::LINE_ADDR_WIDTH-1:0] mem_line_addr,
	output logic [cache_pkg::LINE_WIDTH-1:0]      mem_wdata,
	output logic                                 refill_done,
	output logic [cache_pkg::LINE_WIDTH-1:0]      refill_line
);

	typedef enum logic [2:0] {
		st_idle,
		st_wb,        // Writeback req high
		st_wb_rel,    // Writeback req low, waiting for ack to drop
		st_rd,
		st_rd_rel
	} state_t;

	state_t state;

	logic [cache_pkg::LINE_ADDR_WIDTH-1:0] miss_addr_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= st_idle;
			mem_req     <= 1'b0;
			mem_we      <= 1'b0;
			refill_done <= 1'b0;
		end else begin
			refill_done <= 1'b0;
			case (state)
				st_idle: if (miss_start) begin
					mem_req <= 1'b1;
					mem_we  <= victim_dirty;
					state   <= victim_dirty ? st_wb : st_rd;
				end
				st_wb: if (mem_ack) begin
					mem_req <= 1'b0;
					state   <= st_wb_rel;
				end
				st_wb_rel: if (!mem_ack) begin
					mem_req <= 1'b1;   // Fetch starts once the writeback is closed
					mem_we  <= 1'b0;
					state   <= st_rd;
				end
				st_rd: if (mem_ack) begin
					mem_req <= 1'b0;
					state   <= st_rd_rel;
				end
				st_rd_rel: if (!mem_ack) begin
					refill_done <= 1'b1;
					state       <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Address and line payload
	always_ff @(posedge clk) begin
		if (state == st_idle && miss_start) begin
			miss_addr_q   <= miss_line_addr;
			mem_line_addr <= victim_dirty ? victim_line_addr : miss_line_addr;
			mem_wdata     <= victim_data;
		end
		if (state == st_wb_rel && !mem_ack)
			mem_line_addr <= miss_addr_q;
		if (state == st_rd && mem_ack)
			refill_line <= mem_rdata;
	end

endmodule

// File: design/banked_cache.sv
module banked_cache (
	input  logic                                 clk,
	input  logic                                 rst_n,
	// Requester side
	input  logic                                 cpu_req,
	input  logic                                 cpu_we,
	input  logic [cache_pkg::ADDR_WIDTH-1:0]      cpu_addr,
	input  logic [cache_pkg::WORD_WIDTH-1:0]      cpu_wdata,
	output logic                                 cpu_ack,
	output logic [cache_pkg::WORD_WIDTH-1:0]      cpu_rdata,
	// Memory side
	output logic                                 mem_req,
	output logic                                 mem_we,
	output logic [cache_pkg::LINE_ADDR_WIDTH-1:0] mem_line_addr,
	output logic [cache_pkg::LINE_WIDTH-1:0]      mem_wdata,
	input  logic                                 mem_ack,
	input  logic [cache_pkg::LINE_WIDTH-1:0]      mem_rdata
);

	// ~~~~~~~~~~~~~~~~~~~~
	// Internal nets
	// ~~~~~~~~~~~~~~~~~~~~

	logic [cache_pkg::NUM_BANKS-1:0]    lookup;
	logic [cache_pkg::SET_WIDTH-1:0]    set;
	logic [cache_pkg::TAG_WIDTH-1:0]    tag;
	logic [cache_pkg::BANK_WIDTH-1:0]   bank;
	logic [cache_pkg::OFFSET_WIDTH-1:0] offset;
	logic                              is_write;
	logic [cache_pkg::WORD_WIDTH-1:0]   wdata;
	logic                              start;
	logic                              done;

	logic [cache_pkg::NUM_BANKS-1:0][cache_pkg::LINE_WIDTH-1:0] bank_data;
	logic [cache_pkg::NUM_BANKS-1:0][cache_pkg::TAG_WIDTH-1:0]  bank_victim_tag;
	logic [cache_pkg::NUM_BANKS-1:0]                          bank_dirty;
	logic [cache_pkg::NUM_BANKS-1:0]                          bank_hit;
	logic [cache_pkg::NUM_BANKS-1:0]                          write_en;
	logic [cache_pkg::LINE_WIDTH-1:0]                         data_write;
	logic                                                    dirty_write;

	logic                                 miss_start;
	logic                                 victim_dirty;
	logic [cache_pkg::LINE_ADDR_WIDTH-1:0] victim_line_addr;
	logic [cache_pkg::LINE_WIDTH-1:0]      victim_data;
	logic [cache_pkg::LINE_ADDR_WIDTH-1:0] miss_line_addr;
	logic                                 refill_done;
	logic [cache_pkg::LINE_WIDTH-1:0]      refill_line;

	assign miss_line_addr = {tag, set, bank};   // Requested line, offset dropped

	request_dispatch u_dispatch (
		.clk(clk), .rst_n(rst_n),
		.cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.done(done), .cpu_ack(cpu_ack), .lookup(lookup),
		.set(set), .tag(tag), .bank(bank), .offset(offset),
		.is_write(is_write), .wdata(wdata), .start(start)
	);

	for (genvar i = 0; i < cache_pkg::NUM_BANKS; i++) begin : g_bank
		line_store u_store (
			.clk(clk), .rst_n(rst_n),
			.lookup(lookup[i]), .set(set), .tag(tag),
			.write_en(write_en[i]), .data_write(data_write), .dirty_write(dirty_write),
			.data_read(bank_data[i]), .dirty_read(bank_dirty[i]),
			.hit(bank_hit[i]), .victim_tag(bank_victim_tag[i])
		);
	end

	lookup_resolver u_resolver (
		.clk(clk), .rst_n(rst_n), .start(start),
		.bank(bank), .set(set), .tag(tag), .offset(offset),
		.is_write(is_write), .wdata(wdata),
		.data_read(bank_data), .dirty_read(bank_dirty), .hit(bank_hit),
		.victim_tag(bank_victim_tag),
		.refill_done(refill_done), .refill_line(refill_line),
		.done(done), .cpu_rdata(cpu_rdata), .write_en(write_en),
		.data_write(data_write), .dirty_write(dirty_write),
		.miss_start(miss_start), .victim_dirty(victim_dirty),
		.victim_line_addr(victim_line_addr), .victim_data(victim_data)
	);

	refill_engine u_refill (
		.clk(clk), .rst_n(rst_n),
		.miss_start(miss_start), .victim_dirty(victim_dirty),
		.victim_line_addr(victim_line_addr), .victim_data(victim_data),
		.miss_line_addr(miss_line_addr),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.mem_req(mem_req), .mem_we(mem_we),
		.mem_line_addr(mem_line_addr), .mem_wdata(mem_wdata),
		.refill_done(refill_done), .refill_line(refill_line)
	);

endmodule

// File: tests/backing_memory.sv
module backing_memory (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 mem_req,
	input  logic                                 mem_we,
	input  logic [cache_pkg::LINE_ADDR_WIDTH-1:0] mem_line_addr,
	input  logic [cache_pkg::LINE_WIDTH-1:0]      mem_wdata,
	output logic                                 mem_ack,
	output logic [cache_pkg::LINE_WIDTH-1:0]      mem_rdata,
	output int                                   wb_count,
	output int                                   fetch_count,
	output logic [cache_pkg::LINE_ADDR_WIDTH-1:0] last_wb_addr,
	output logic [cache_pkg::LINE_WIDTH-1:0]      last_wb_data
);
	timeunit 1ns;
	timeprecision 1ps;

	// Only written lines are stored, the rest come from the pattern
	logic [cache_pkg::LINE_WIDTH-1:0] lines [logic [cache_pkg::LINE_ADDR_WIDTH-1:0]];
	int wait_cnt;

	function automatic logic [cache_pkg::LINE_WIDTH-1:0] initial_line(
			input logic [cache_pkg::LINE_ADDR_WIDTH-1:0] line_addr);
		logic [cache_pkg::LINE_WIDTH-1:0] line;
		for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++)
			line[w*32 +: 32] = {16'h0, line_addr, 2'(w)} ^ 32'hC0DE0000;
		return line;
	endfunction

	// The memory port is quiet before the first clock edge
	initial begin
		mem_ack   = 1'b0;
		mem_rdata = '0;
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			mem_ack     <= 1'b0;
			wait_cnt    <= 0;
			wb_count    <= 0;
			fetch_count <= 0;
		end else if (mem_req && !mem_ack) begin
			if (wait_cnt < 2) begin
				wait_cnt <= wait_cnt + 1;   // Slow answer keeps the refill engine stalled
			end else begin
				wait_cnt <= 0;
				mem_ack  <= 1'b1;
				if (mem_we) begin
					lines[mem_line_addr] = mem_wdata;
					last_wb_addr <= mem_line_addr;
					last_wb_data <= mem_wdata;
					wb_count     <= wb_count + 1;
				end else begin
					mem_rdata   <= lines.exists(mem_line_addr) ? lines[mem_line_addr]
						: initial_line(mem_line_addr);
					fetch_count <= fetch_count + 1;
				end
			end
		end else if (!mem_req && mem_ack) begin
			mem_ack <= 1'b0;
		end
	end

endmodule

// File: tests/cache_properties.sv
module cache_properties (
	input logic clk,
	input logic rst_n,
	input logic cpu_req,
	input logic cpu_ack,
	input logic mem_req,
	input logic mem_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;   // Handshake rules broken so far

	task automatic report_violation(input string rule);
		$error("Handshake rule broken: %s", rule);
		fail_count++;
	endtask

	reset_low: assert property (@(posedge clk) !rst_n |=> !cpu_ack && !mem_req)
		else report_violation("cpu_ack or mem_req high after reset");

	// ~~~~~~~~~~~~~~~~~~~~
	// Requester handshake
	// ~~~~~~~~~~~~~~~~~~~~

	cpu_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cpu_ack) |-> cpu_req) else report_violation("cpu_ack rose without cpu_req");
	cpu_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_req && !cpu_ack |=> cpu_req) else report_violation("cpu_req dropped before cpu_ack");
	cpu_ack_drops: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ack && !cpu_req |=> !cpu_ack) else report_violation("cpu_ack stayed high");

	// ~~~~~~~~~~~~~~~~~~~~
	// Memory handshake
	// ~~~~~~~~~~~~~~~~~~~~

	mem_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_ack) |-> mem_req) else report_violation("mem_ack rose without mem_req");
	mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && !mem_ack |=> mem_req) else report_violation("mem_req dropped before mem_ack");
	mem_ack_drops: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ack && !mem_req |=> !mem_ack) else report_violation("mem_ack stayed high");

endmodule

// File: tests/cache_tb.sv
module cache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ENTRIES = 20;
	localparam int NUM_RANDOM  = 64;

	typedef struct {
		logic                                 we;
		logic [cache_pkg::ADDR_WIDTH-1:0]      addr;
		logic [cache_pkg::WORD_WIDTH-1:0]      wdata;
		logic [cache_pkg::WORD_WIDTH-1:0]      rdata;
		int                                   fetches;
		int                                   wbs;
		logic [cache_pkg::LINE_ADDR_WIDTH-1:0] wb_line;   // Victim line when wbs is 1
	} entry_t;

	logic clk = 1'b0;
	logic rst_n, cpu_req, cpu_we, cpu_ack, mem_req, mem_we, mem_ack;
	logic [cache_pkg::ADDR_WIDTH-1:0]      cpu_addr;
	logic [cache_pkg::WORD_WIDTH-1:0]      cpu_wdata, cpu_rdata;
	logic [cache_pkg::LINE_ADDR_WIDTH-1:0] mem_line_addr, last_wb_addr;
	logic [cache_pkg::LINE_WIDTH-1:0]      mem_wdata, mem_rdata, last_wb_data;
	int wb_count, fetch_count;

	entry_t stim [NUM_ENTRIES];
	logic [cache_pkg::WORD_WIDTH-1:0] shadow [logic [cache_pkg::ADDR_WIDTH-1:0]];
	logic [15:0] lfsr = 16'd20;
	int n_entries = 0;
	int check_count = 0;
	int error_count = 0;

	always #4 clk = ~clk;

	banked_cache DUT (.*);
	backing_memory u_mem (.*);

	bind banked_cache cache_properties u_props (
		.clk(clk), .rst_n(rst_n), .cpu_req(cpu_req), .cpu_ack(cpu_ack),
		.mem_req(mem_req), .mem_ack(mem_ack)
	);

	function automatic logic [31:0] initial_word(input logic [15:0] addr);
		return {16'h0, addr} ^ 32'hC0DE0000;
	endfunction

	function automatic logic [31:0] expected_word(input logic [15:0] addr);
		return shadow.exists(addr) ? shadow[addr] : initial_word(addr);
	endfunction

	// Taps 16 14 13 11, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("Error: %s is %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic check_writeback();   // The written line must match the shadow
		for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++)
			check_equal("mem_wdata", last_wb_data[w*32 +: 32],
				expected_word({last_wb_addr, 2'(w)}));
	endtask

	// For a write the expected word doubles as the write data
	task automatic add_entry(input logic we, input logic [15:0] addr, input logic [31:0] rdata,
			input int fetches, input int wbs = 0, input logic [13:0] wb_line = '0);
		stim[n_entries] = '{we, addr, rdata, rdata, fetches, wbs, wb_line};
		n_entries++;
	endtask

	task automatic run_request(input logic we, input logic [15:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge clk);
		cpu_req   <= 1'b1;
		cpu_we    <= we;
		cpu_addr  <= addr;
		cpu_wdata <= wdata;
		do @(posedge clk); while (!cpu_ack);
		rdata = cpu_rdata;
		cpu_req <= 1'b0;
		do @(posedge clk); while (cpu_ack);
	endtask

	initial begin
		logic [31:0] rdata;
		logic [31:0] bits;
		logic [31:0] wdata;
		logic [15:0] addr;
		logic        we;
		int          fetch_before;
		int          wb_before;

		rst_n     = 1'b0;
		cpu_req   = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		add_entry(1'b0, 16'h1234, initial_word(16'h1234), 1);   // Cold miss
		add_entry(1'b1, 16'h1235, 32'hA5A50001, 0);
		add_entry(1'b0, 16'h1235, 32'hA5A50001, 0);
		add_entry(1'b0, 16'h1236, initial_word(16'h1236), 0);
		add_entry(1'b0, 16'h1237, initial_word(16'h1237), 0);
		add_entry(1'b0, 16'h1234, initial_word(16'h1234), 0);
		add_entry(1'b1, 16'h2040, 32'h0BADF00D, 1);   // Write allocate
		add_entry(1'b0, 16'h2041, initial_word(16'h2041), 0);
		add_entry(1'b0, 16'h3040, initial_word(16'h3040), 1, 1, 14'h810);   // Evicts 2040
		add_entry(1'b0, 16'h2040, 32'h0BADF00D, 1);
		add_entry(1'b0, 16'h2041, initial_word(16'h2041), 0);
		add_entry(1'b1, 16'h5000, 32'h11110000, 1);   // Same set in all four banks
		add_entry(1'b1, 16'h5004, 32'h22220001, 1);
		add_entry(1'b1, 16'h5008, 32'h33330002, 1);
		add_entry(1'b1, 16'h500C, 32'h44440003, 1);
		add_entry(1'b0, 16'h5000, 32'h11110000, 0);
		add_entry(1'b0, 16'h5004, 32'h22220001, 0);
		add_entry(1'b0, 16'h5008, 32'h33330002, 0);
		add_entry(1'b0, 16'h500C, 32'h44440003, 0);
		add_entry(1'b0, 16'h500D, initial_word(16'h500D), 0);

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_equal("cpu_ack", 32'(cpu_ack), 32'h0);
		check_equal("mem_req", 32'(mem_req), 32'h0);

		// ~~~~~~~~~~~~~~~~~~~~
		// Directed table
		// ~~~~~~~~~~~~~~~~~~~~
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			fetch_before = fetch_count;
			wb_before    = wb_count;
			run_request(stim[i].we, stim[i].addr, stim[i].wdata, rdata);
			if (stim[i].we)
				shadow[stim[i].addr] = stim[i].wdata;
			check_equal("cpu_rdata", rdata, stim[i].rdata);
			check_equal("fetch_count", fetch_count - fetch_before, stim[i].fetches);
			check_equal("wb_count", wb_count - wb_before, stim[i].wbs);
			if (stim[i].wbs != 0)
				check_equal("last_wb_addr", 32'(last_wb_addr), 32'(stim[i].wb_line));
			if (wb_count != wb_before)
				check_writeback();
		end

		// ~~~~~~~~~~~~~~~~~~~~
		// Random traffic
		// ~~~~~~~~~~~~~~~~~~~~
		for (int i = 0; i < NUM_RANDOM; i++) begin
			bits  = rand_bits(1);
			we    = bits[0];
			bits  = rand_bits(8);
			addr  = {6'h18, bits[7:6], 2'b00, bits[5:0]};   // Four tags over four sets
			wdata = rand_bits(32);
			wb_before = wb_count;
			run_request(we, addr, wdata, rdata);
			check_equal("cpu_rdata", rdata, we ? wdata : expected_word(addr));
			if (we)
				shadow[addr] = wdata;
			if (wb_count != wb_before)
				check_writeback();
		end

		$display("Checks: %0d, errors: %0d, property failures: %0d",
			check_count, error_count, DUT.u_props.fail_count);
		if (error_count == 0 && DUT.u_props.fail_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		repeat ((NUM_ENTRIES + NUM_RANDOM) * 40) @(posedge clk);
		$display("Timeout with the requests still running, %0d errors so far", error_count);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: list.f
design/cache_pkg.sv
design/line_store.sv
design/request_dispatch.sv
design/lookup_resolver.sv
design/refill_engine.sv
design/banked_cache.sv
tests/backing_memory.sv
tests/cache_properties.sv
tests/cache_tb.sv
